// File: common/draw_pkg.sv
package draw_pkg;

    // ==================================================================
    // Screen geometry and field widths
    // ==================================================================
    localparam int screen_w     = 160;
    localparam int screen_h     = 120;
    localparam int x_width      = 8;
    localparam int y_width      = 7;
    localparam int colour_width = 3;

    // Bresenham error terms need a sign bit and headroom for 2*err
    localparam int err_width = x_width + 4;

    // ==================================================================
    // Host register map
    // ==================================================================
    localparam logic [2:0] reg_x0     = 3'd0;
    localparam logic [2:0] reg_y0     = 3'd1;
    localparam logic [2:0] reg_x1     = 3'd2;
    localparam logic [2:0] reg_y1     = 3'd3;
    localparam logic [2:0] reg_colour = 3'd4;
    localparam logic [2:0] reg_cmd    = 3'd5;
    localparam logic [2:0] reg_status = 3'd6;

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_clear = 2'd1,
        op_line  = 2'd2,
        op_box   = 2'd3
    } draw_op_e;

    typedef enum logic [1:0] {
        raster_idle,
        raster_draw,
        raster_done
    } raster_state_e;

    typedef enum logic [2:0] {
        seq_idle,
        seq_clear,
        seq_line,
        seq_box_edge,
        seq_edge_gap,
        seq_finish
    } seq_state_e;

endpackage

// File: hdl/draw_regs.sv
`timescale 1ns/1ps

module draw_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              reg_wr,
    input  logic [2:0]                        reg_addr,
    input  logic [7:0]                        reg_wdata,
    input  logic                              cmd_done,
    output logic [7:0]                        reg_rdata,
    output logic                              cmd_go,
    output draw_pkg::draw_op_e                cmd_op,
    output logic [draw_pkg::x_width-1:0]      x0,
    output logic [draw_pkg::y_width-1:0]      y0,
    output logic [draw_pkg::x_width-1:0]      x1,
    output logic [draw_pkg::y_width-1:0]      y1,
    output logic [draw_pkg::colour_width-1:0] colour,
    output logic                              busy
);

    import draw_pkg::*;

    logic dropped;
    logic cmd_valid;

    // Only the four encoded opcodes with clear upper bits start anything,
    // and op_none is a no-op
    assign cmd_valid = (reg_wdata[7:2] == 6'd0) && (reg_wdata[1:0] != op_none);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            dropped <= 1'b0;
            cmd_go  <= 1'b0;
            cmd_op  <= op_none;
        end else begin
            cmd_go <= 1'b0;
            if (cmd_done) begin
                busy <= 1'b0;
            end
            if (reg_wr) begin
                case (reg_addr)
                    reg_x0:     x0     <= reg_wdata[x_width-1:0];
                    reg_y0:     y0     <= reg_wdata[y_width-1:0];
                    reg_x1:     x1     <= reg_wdata[x_width-1:0];
                    reg_y1:     y1     <= reg_wdata[y_width-1:0];
                    reg_colour: colour <= reg_wdata[colour_width-1:0];
                    reg_cmd: begin
                        if (busy) begin
                            dropped <= 1'b1;
                        end else begin
                            cmd_op <= draw_op_e'(reg_wdata[1:0]);
                            if (cmd_valid) begin
                                cmd_go <= 1'b1;
                                busy   <= 1'b1;
                            end
                        end
                    end
                    reg_status: dropped <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_addr)
            reg_x0:     reg_rdata = x0;
            reg_y0:     reg_rdata = {1'b0, y0};
            reg_x1:     reg_rdata = x1;
            reg_y1:     reg_rdata = {1'b0, y1};
            reg_colour: reg_rdata = {5'd0, colour};
            reg_cmd:    reg_rdata = {6'd0, cmd_op};
            reg_status: reg_rdata = {6'd0, dropped, busy};
            default:    reg_rdata = 8'd0;
        endcase
    end

endmodule

// File: line/line_raster.sv
`timescale 1ns/1ps

module line_raster (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [draw_pkg::colour_width-1:0] colour,
    input  logic [draw_pkg::x_width-1:0]      x0,
    input  logic [draw_pkg::y_width-1:0]      y0,
    input  logic [draw_pkg::x_width-1:0]      x1,
    input  logic [draw_pkg::y_width-1:0]      y1,
    input  logic                              start,
    output logic                              done,
    output logic [draw_pkg::x_width-1:0]      vga_x,
    output logic [draw_pkg::y_width-1:0]      vga_y,
    output logic [draw_pkg::colour_width-1:0] vga_colour,
    output logic                              vga_plot
);

    import draw_pkg::*;

    raster_state_e state;

    logic [x_width-1:0]          x;
    logic [y_width-1:0]          y;
    logic [colour_width-1:0]     colour_q;
    logic                        x_inc;
    logic                        y_inc;
    logic signed [err_width-1:0] dx;
    logic signed [err_width-1:0] dy;
    logic signed [err_width-1:0] err;

    logic [x_width-1:0]          adx;
    logic [y_width-1:0]          ady;
    logic signed [err_width-1:0] dx_init;
    logic signed [err_width-1:0] dy_init;
    logic signed [err_width-1:0] e2;
    logic signed [err_width-1:0] err_nxt;
    logic                        step_x;
    logic                        step_y;
    logic [x_width-1:0]          x_nxt;
    logic [y_width-1:0]          y_nxt;

    function automatic logic on_screen(input logic [x_width-1:0] px,
                                       input logic [y_width-1:0] py);
        return (px < screen_w) && (py < screen_h);
    endfunction

    // ==================================================================
    // Setup terms and one Bresenham step
    // ==================================================================
    always_comb begin
        adx     = (x1 >= x0) ? x1 - x0 : x0 - x1;
        ady     = (y1 >= y0) ? y1 - y0 : y0 - y1;
        dx_init = err_width'(adx);
        dy_init = -err_width'(ady);

        e2     = err <<< 1;
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);

        err_nxt = err;
        x_nxt   = x;
        y_nxt   = y;
        if (step_x) begin
            err_nxt = err_nxt + dy;
            x_nxt   = x_inc ? x + 1'b1 : x - 1'b1;
        end
        if (step_y) begin
            err_nxt = err_nxt + dx;
            y_nxt   = y_inc ? y + 1'b1 : y - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= raster_idle;
            vga_plot <= 1'b0;
            done     <= 1'b0;
        end else begin
            case (state)
                raster_idle: begin
                    if (start) begin
                        state    <= raster_draw;
                        colour_q <= colour;
                        x        <= x0;
                        y        <= y0;
                        x_inc    <= (x1 >= x0);
                        y_inc    <= (y1 >= y0);
                        dx       <= dx_init;
                        dy       <= dy_init;
                        err      <= dx_init + dy_init;
                        vga_plot <= on_screen(x0, y0);
                    end
                end
                raster_draw: begin
                    if (!start) begin
                        state    <= raster_idle;
                        vga_plot <= 1'b0;
                    end else if (x == x1 && y == y1) begin
                        state    <= raster_done;
                        vga_plot <= 1'b0;
                        done     <= 1'b1;
                    end else begin
                        x        <= x_nxt;
                        y        <= y_nxt;
                        err      <= err_nxt;
                        // Clipped pixels still use up their cycle
                        vga_plot <= on_screen(x_nxt, y_nxt);
                    end
                end
                raster_done: begin
                    if (!start) begin
                        state <= raster_idle;
                        done  <= 1'b0;
                    end
                end
                default: begin
                    state    <= raster_idle;
                    vga_plot <= 1'b0;
                    done     <= 1'b0;
                end
            endcase
        end
    end

    assign vga_x      = x;
    assign vga_y      = y;
    assign vga_colour = colour_q;

endmodule

// File: fill/screen_fill.sv
`timescale 1ns/1ps

module screen_fill (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [draw_pkg::colour_width-1:0] colour,
    input  logic                              start,
    output logic                              done,
    output logic [draw_pkg::x_width-1:0]      vga_x,
    output logic [draw_pkg::y_width-1:0]      vga_y,
    output logic [draw_pkg::colour_width-1:0] vga_colour,
    output logic                              vga_plot
);

    import draw_pkg::*;

    raster_state_e state;

    logic [x_width-1:0]      x;
    logic [y_width-1:0]      y;
    logic [colour_width-1:0] colour_q;
    logic                    x_last;
    logic                    y_last;

    assign x_last = (x == x_width'(screen_w - 1));
    assign y_last = (y == y_width'(screen_h - 1));

    // Same start and done handshake as the line rasterizer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= raster_idle;
            vga_plot <= 1'b0;
            done     <= 1'b0;
        end else begin
            case (state)
                raster_idle: begin
                    if (start) begin
                        state    <= raster_draw;
                        colour_q <= colour;
                        x        <= '0;
                        y        <= '0;
                        vga_plot <= 1'b1;
                    end
                end
                raster_draw: begin
                    if (!start) begin
                        state    <= raster_idle;
                        vga_plot <= 1'b0;
                    end else if (x_last && y_last) begin
                        state    <= raster_done;
                        vga_plot <= 1'b0;
                        done     <= 1'b1;
                    end else if (x_last) begin
                        x <= '0;
                        y <= y + 1'b1;
                    end else begin
                        x <= x + 1'b1;
                    end
                end
                raster_done: begin
                    if (!start) begin
                        state <= raster_idle;
                        done  <= 1'b0;
                    end
                end
                default: begin
                    state    <= raster_idle;
                    vga_plot <= 1'b0;
                    done     <= 1'b0;
                end
            endcase
        end
    end

    assign vga_x      = x;
    assign vga_y      = y;
    assign vga_colour = colour_q;

endmodule

// File: hdl/draw_sequencer.sv
`timescale 1ns/1ps

module draw_sequencer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cmd_go,
    input  draw_pkg::draw_op_e                cmd_op,
    input  logic [draw_pkg::x_width-1:0]      x0,
    input  logic [draw_pkg::y_width-1:0]      y0,
    input  logic [draw_pkg::x_width-1:0]      x1,
    input  logic [draw_pkg::y_width-1:0]      y1,
    input  logic [draw_pkg::colour_width-1:0] colour,
    input  logic                              line_done,
    input  logic [draw_pkg::x_width-1:0]      line_x,
    input  logic [draw_pkg::y_width-1:0]      line_y,
    input  logic [draw_pkg::colour_width-1:0] line_colour,
    input  logic                              line_plot,
    input  logic                              fill_done,
    input  logic [draw_pkg::x_width-1:0]      fill_x,
    input  logic [draw_pkg::y_width-1:0]      fill_y,
    input  logic [draw_pkg::colour_width-1:0] fill_colour,
    input  logic                              fill_plot,
    output logic                              cmd_done,
    output logic                              line_start,
    output logic [draw_pkg::x_width-1:0]      lx0,
    output logic [draw_pkg::y_width-1:0]      ly0,
    output logic [draw_pkg::x_width-1:0]      lx1,
    output logic [draw_pkg::y_width-1:0]      ly1,
    output logic [draw_pkg::colour_width-1:0] line_col_in,
    output logic                              fill_start,
    output logic [draw_pkg::colour_width-1:0] fill_col_in,
    output logic [draw_pkg::x_width-1:0]      pix_x,
    output logic [draw_pkg::y_width-1:0]      pix_y,
    output logic [draw_pkg::colour_width-1:0] pix_colour,
    output logic                              pix_plot
);

    import draw_pkg::*;

    seq_state_e state;

    logic [1:0]              edge_cnt;
    logic [x_width-1:0]      cx0;
    logic [y_width-1:0]      cy0;
    logic [x_width-1:0]      cx1;
    logic [y_width-1:0]      cy1;
    logic [colour_width-1:0] col_q;
    logic                    use_fill;

    // ==================================================================
    // Command FSM
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= seq_idle;
            edge_cnt <= 2'd0;
        end else begin
            case (state)
                seq_idle: begin
                    if (cmd_go) begin
                        cx0      <= x0;
                        cy0      <= y0;
                        cx1      <= x1;
                        cy1      <= y1;
                        col_q    <= colour;
                        edge_cnt <= 2'd0;
                        case (cmd_op)
                            op_clear: state <= seq_clear;
                            op_line:  state <= seq_line;
                            op_box:   state <= seq_box_edge;
                            default:  state <= seq_finish;
                        endcase
                    end
                end
                seq_clear: if (fill_done) state <= seq_finish;
                seq_line:  if (line_done) state <= seq_finish;
                seq_box_edge: begin
                    if (line_done) begin
                        if (edge_cnt == 2'd3) begin
                            state <= seq_finish;
                        end else begin
                            edge_cnt <= edge_cnt + 2'd1;
                            state    <= seq_edge_gap;
                        end
                    end
                end
                // Start stays low here so the rasterizer drops back to idle
                seq_edge_gap: state <= seq_box_edge;
                default:      state <= seq_idle;
            endcase
        end
    end

    // Box edges run clockwise from (x0,y0) and share their corners
    always_comb begin
        lx0 = cx0;
        ly0 = cy0;
        lx1 = cx1;
        ly1 = cy1;
        if (state == seq_box_edge || state == seq_edge_gap) begin
            case (edge_cnt)
                2'd0: ly1 = cy0;
                2'd1: lx0 = cx1;
                2'd2: begin
                    lx0 = cx1;
                    ly0 = cy1;
                    lx1 = cx0;
                end
                default: begin
                    ly0 = cy1;
                    lx1 = cx0;
                    ly1 = cy0;
                end
            endcase
        end
    end

    assign line_start  = (state == seq_line) || (state == seq_box_edge);
    assign fill_start  = (state == seq_clear);
    assign cmd_done    = (state == seq_finish);
    assign line_col_in = col_q;
    assign fill_col_in = col_q;

    // Pixel source follows the state, so there is no extra latency
    assign use_fill   = (state == seq_clear);
    assign pix_x      = use_fill ? fill_x      : line_x;
    assign pix_y      = use_fill ? fill_y      : line_y;
    assign pix_colour = use_fill ? fill_colour : line_colour;
    assign pix_plot   = use_fill ? fill_plot   : line_plot;

endmodule

// File: hdl/draw_engine.sv
`timescale 1ns/1ps

module draw_engine (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              reg_wr,
    input  logic [2:0]                        reg_addr,
    input  logic [7:0]                        reg_wdata,
    output logic [7:0]                        reg_rdata,
    output logic [draw_pkg::x_width-1:0]      pix_x,
    output logic [draw_pkg::y_width-1:0]      pix_y,
    output logic [draw_pkg::colour_width-1:0] pix_colour,
    output logic                              pix_plot,
    output logic                              cmd_done
);

    import draw_pkg::*;

    logic                    cmd_go;
    draw_op_e                cmd_op;
    logic [x_width-1:0]      x0;
    logic [y_width-1:0]      y0;
    logic [x_width-1:0]      x1;
    logic [y_width-1:0]      y1;
    logic [colour_width-1:0] colour;
    logic                    busy;

    logic                    line_start;
    logic                    line_done;
    logic [x_width-1:0]      lx0;
    logic [y_width-1:0]      ly0;
    logic [x_width-1:0]      lx1;
    logic [y_width-1:0]      ly1;
    logic [colour_width-1:0] line_col_in;
    logic [x_width-1:0]      line_x;
    logic [y_width-1:0]      line_y;
    logic [colour_width-1:0] line_colour;
    logic                    line_plot;

    logic                    fill_start;
    logic                    fill_done;
    logic [colour_width-1:0] fill_col_in;
    logic [x_width-1:0]      fill_x;
    logic [y_width-1:0]      fill_y;
    logic [colour_width-1:0] fill_colour;
    logic                    fill_plot;

    draw_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .cmd_done  (cmd_done),
        .reg_rdata (reg_rdata),
        .cmd_go    (cmd_go),
        .cmd_op    (cmd_op),
        .x0        (x0),
        .y0        (y0),
        .x1        (x1),
        .y1        (y1),
        .colour    (colour),
        .busy      (busy)
    );

    draw_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_go      (cmd_go),
        .cmd_op      (cmd_op),
        .x0          (x0),
        .y0          (y0),
        .x1          (x1),
        .y1          (y1),
        .colour      (colour),
        .line_done   (line_done),
        .line_x      (line_x),
        .line_y      (line_y),
        .line_colour (line_colour),
        .line_plot   (line_plot),
        .fill_done   (fill_done),
        .fill_x      (fill_x),
        .fill_y      (fill_y),
        .fill_colour (fill_colour),
        .fill_plot   (fill_plot),
        .cmd_done    (cmd_done),
        .line_start  (line_start),
        .lx0         (lx0),
        .ly0         (ly0),
        .lx1         (lx1),
        .ly1         (ly1),
        .line_col_in (line_col_in),
        .fill_start  (fill_start),
        .fill_col_in (fill_col_in),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_colour  (pix_colour),
        .pix_plot    (pix_plot)
    );

    line_raster u_line (
        .clk        (clk),
        .rst_n      (rst_n),
        .colour     (line_col_in),
        .x0         (lx0),
        .y0         (ly0),
        .x1         (lx1),
        .y1         (ly1),
        .start      (line_start),
        .done       (line_done),
        .vga_x      (line_x),
        .vga_y      (line_y),
        .vga_colour (line_colour),
        .vga_plot   (line_plot)
    );

    screen_fill u_fill (
        .clk        (clk),
        .rst_n      (rst_n),
        .colour     (fill_col_in),
        .start      (fill_start),
        .done       (fill_done),
        .vga_x      (fill_x),
        .vga_y      (fill_y),
        .vga_colour (fill_colour),
        .vga_plot   (fill_plot)
    );

endmodule

// File: test/draw_engine_props.sv
`timescale 1ns/1ps

module draw_engine_props (
    input logic clk,
    input logic rst_n,
    input logic cmd_done,
    input logic busy,
    input logic line_start,
    input logic fill_start,
    input logic pix_plot,
    input logic seq_idle
);

    cmd_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_done |=> !cmd_done)
        else $error("cmd_done stayed high for more than one cycle");

    // The sequencer runs only one engine at a time
    start_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(line_start && fill_start))
        else $error("line_start and fill_start are high together");

    no_plot_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        seq_idle |-> !pix_plot)
        else $error("pix_plot is high while the sequencer is idle");

    busy_release: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_done |=> !busy)
        else $error("busy did not fall one cycle after cmd_done");

    busy_fall_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(cmd_done))
        else $error("busy fell without a preceding cmd_done");

endmodule

bind draw_regs draw_engine_props regs_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_done   (cmd_done),
    .busy       (busy),
    .line_start (1'b0),
    .fill_start (1'b0),
    .pix_plot   (1'b0),
    .seq_idle   (1'b0)
);

bind draw_sequencer draw_engine_props seq_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_done   (cmd_done),
    .busy       (1'b0),
    .line_start (line_start),
    .fill_start (fill_start),
    .pix_plot   (pix_plot),
    .seq_idle   (state == draw_pkg::seq_idle)
);

// File: test/tb_draw_engine.sv
`timescale 1ns/1ps

module tb_draw_engine;

    import draw_pkg::*;

    // Two clears plus about forty lines and box edges, with margin
    localparam int timeout_cycles = 2 * 19200 + 40 * 260 + 11200;

    logic       clk;
    logic       rst_n;
    logic       reg_wr;
    logic [2:0] reg_addr;
    logic [7:0] reg_wdata;
    logic [7:0] reg_rdata;
    logic [7:0] pix_x;
    logic [6:0] pix_y;
    logic [2:0] pix_colour;
    logic       pix_plot;
    logic       cmd_done;

    logic [17:0] got_q[$];
    logic [17:0] exp_q[$];
    int          errors = 0;
    int          cycles = 0;
    int          seed = 32'hf8e26828;

    draw_engine dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_colour (pix_colour),
        .pix_plot   (pix_plot),
        .cmd_done   (cmd_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("Timeout: the DUT did not finish within %0d cycles", timeout_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // Pixels are captured mid-cycle where the registered outputs are settled
    always @(negedge clk) begin
        if (rst_n && pix_plot) begin
            got_q.push_back({pix_colour, pix_x, pix_y});
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic void report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endfunction

    function automatic int iabs(input int v);
        return (v < 0) ? -v : v;
    endfunction

    // Reference Bresenham walk, keeping only pixels that land on the screen
    function automatic void add_line(input int ax, input int ay, input int bx,
                                     input int by, input int col);
        int dx;
        int dy;
        int err;
        int e2;
        int x;
        int y;
        bit fin;
        dx  = iabs(bx - ax);
        dy  = -iabs(by - ay);
        err = dx + dy;
        x   = ax;
        y   = ay;
        fin = 1'b0;
        while (!fin) begin
            if (x < screen_w && y < screen_h) begin
                exp_q.push_back({3'(col), 8'(x), 7'(y)});
            end
            if (x == bx && y == by) begin
                fin = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err = err + dy;
                    x   = (bx > ax) ? x + 1 : x - 1;
                end
                if (e2 <= dx) begin
                    err = err + dx;
                    y   = (by > ay) ? y + 1 : y - 1;
                end
            end
        end
    endfunction

    task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [7:0] data);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic load_regs(input int ax, input int ay, input int bx, input int by,
                             input int col);
        write_reg(reg_x0, 8'(ax));
        write_reg(reg_y0, 8'(ay));
        write_reg(reg_x1, 8'(bx));
        write_reg(reg_y1, 8'(by));
        write_reg(reg_colour, 8'(col));
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!cmd_done) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_pixels(input string what);
        int n;
        int bad;
        n   = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        bad = 0;
        assert (got_q.size() == exp_q.size()) else report_mismatch($sformatf(
            "%s gave %0d pixels, expected %0d", what, got_q.size(), exp_q.size()));
        for (int i = 0; i < n && bad < 5; i++) begin
            assert (got_q[i] == exp_q[i]) else begin
                bad++;
                report_mismatch($sformatf(
                    "%s pixel %0d is (%0d,%0d) colour %0d, expected (%0d,%0d) colour %0d",
                    what, i, got_q[i][14:7], got_q[i][6:0], got_q[i][17:15],
                    exp_q[i][14:7], exp_q[i][6:0], exp_q[i][17:15]));
            end
        end
    endtask

    task automatic run_line(input int ax, input int ay, input int bx, input int by,
                            input int col);
        int steps;
        steps = (iabs(bx - ax) > iabs(by - ay)) ? iabs(bx - ax) : iabs(by - ay);
        load_regs(ax, ay, bx, by, col);
        exp_q.delete();
        add_line(ax, ay, bx, by, col);
        got_q.delete();
        write_reg(reg_cmd, op_line);
        wait_done();
        compare_pixels($sformatf("line (%0d,%0d)-(%0d,%0d)", ax, ay, bx, by));
        if (ax < screen_w && bx < screen_w && ay < screen_h && by < screen_h) begin
            assert (got_q.size() == steps + 1) else report_mismatch($sformatf(
                "line of %0d steps plotted %0d pixels", steps, got_q.size()));
        end
    endtask

    task automatic run_box(input int ax, input int ay, input int bx, input int by,
                           input int col);
        int corner;
        load_regs(ax, ay, bx, by, col);
        exp_q.delete();
        add_line(ax, ay, bx, ay, col);
        add_line(bx, ay, bx, by, col);
        add_line(bx, by, ax, by, col);
        add_line(ax, by, ax, ay, col);
        got_q.delete();
        write_reg(reg_cmd, op_box);
        wait_done();
        compare_pixels($sformatf("box (%0d,%0d)-(%0d,%0d)", ax, ay, bx, by));
        corner = 0;
        foreach (got_q[i]) begin
            if (got_q[i] == {3'(col), 8'(ax), 7'(ay)}) begin
                corner++;
            end
        end
        assert (corner == 2) else report_mismatch($sformatf(
            "box start corner plotted %0d times", corner));
    endtask

    function automatic void add_clear(input int col);
        for (int i = 0; i < screen_w * screen_h; i++) begin
            exp_q.push_back({3'(col), 8'(i % screen_w), 7'(i / screen_w)});
        end
    endfunction

    task automatic run_clear(input int col);
        write_reg(reg_colour, 8'(col));
        exp_q.delete();
        add_clear(col);
        got_q.delete();
        write_reg(reg_cmd, op_clear);
        wait_done();
        compare_pixels($sformatf("clear in colour %0d", col));
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic after_reset();
        logic [7:0] st;
        repeat (4) @(negedge clk);
        read_reg(reg_status, st);
        assert (st == 8'h00) else report_mismatch($sformatf("status after reset is %h", st));
        assert (!cmd_done) else report_mismatch("cmd_done high after reset");
        assert (got_q.size() == 0) else report_mismatch("pixels plotted before any command");
    endtask

    task automatic register_readback();
        logic [7:0] rd;
        write_reg(reg_x0, 8'ha5);
        write_reg(reg_y0, 8'hda);
        write_reg(reg_x1, 8'h3c);
        write_reg(reg_y1, 8'h21);
        write_reg(reg_colour, 8'h06);
        read_reg(reg_x0, rd);
        assert (rd == 8'ha5) else report_mismatch($sformatf("x0 reads %h", rd));
        read_reg(reg_y0, rd);
        assert (rd == 8'h5a) else report_mismatch($sformatf("y0 reads %h", rd));
        read_reg(reg_x1, rd);
        assert (rd == 8'h3c) else report_mismatch($sformatf("x1 reads %h", rd));
        read_reg(reg_y1, rd);
        assert (rd == 8'h21) else report_mismatch($sformatf("y1 reads %h", rd));
        read_reg(reg_colour, rd);
        assert (rd == 8'h06) else report_mismatch($sformatf("colour reads %h", rd));
    endtask

    task automatic directed_lines();
        // One line into each octant from the screen centre
        run_line(80, 60, 120, 70, 1);
        run_line(80, 60, 90, 110, 2);
        run_line(80, 60, 70, 110, 3);
        run_line(80, 60, 40, 70, 4);
        run_line(80, 60, 40, 50, 5);
        run_line(80, 60, 70, 10, 6);
        run_line(80, 60, 90, 10, 7);
        run_line(80, 60, 120, 50, 1);
        run_line(5, 5, 5, 5, 2);
        run_line(0, 0, 159, 0, 3);
        run_line(159, 0, 159, 119, 4);
        run_line(150, 100, 200, 127, 5);
    endtask

    task automatic box_outlines();
        run_box(10, 10, 50, 30, 6);
        run_box(150, 110, 100, 100, 3);
        run_box(140, 100, 200, 127, 7);
    endtask

    task automatic dropped_command();
        logic [7:0] st;
        write_reg(reg_colour, 8'd2);
        exp_q.delete();
        add_clear(2);
        got_q.delete();
        write_reg(reg_cmd, op_clear);
        write_reg(reg_cmd, op_line);
        read_reg(reg_status, st);
        assert (st == 8'h03) else report_mismatch($sformatf("status while busy is %h", st));
        wait_done();
        repeat (8) @(negedge clk);
        compare_pixels("clear with a dropped line command");
        read_reg(reg_status, st);
        assert (st == 8'h02) else report_mismatch($sformatf("status after clear is %h", st));
        write_reg(reg_status, 8'h00);
        read_reg(reg_status, st);
        assert (st == 8'h00) else report_mismatch($sformatf("dropped not cleared, %h", st));
    endtask

    task automatic random_lines();
        logic [7:0] st;
        int         ax;
        int         ay;
        int         bx;
        int         by;
        for (int i = 0; i < 20; i++) begin
            ax = $random(seed) & 255;
            ay = $random(seed) & 127;
            bx = $random(seed) & 255;
            by = $random(seed) & 127;
            run_line(ax, ay, bx, by, i % 8);
            read_reg(reg_status, st);
            assert (st[0] == 1'b0) else report_mismatch("busy still high after cmd_done");
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = 3'd0;
        reg_wdata = 8'd0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        after_reset();
        register_readback();
        directed_lines();
        box_outlines();
        run_clear(5);
        dropped_command();
        random_lines();
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb.f
common/draw_pkg.sv
hdl/draw_regs.sv
line/line_raster.sv
fill/screen_fill.sv
hdl/draw_sequencer.sv
hdl/draw_engine.sv
test/draw_engine_props.sv
test/tb_draw_engine.sv

// File: Bender.yml
package:
  name: draw_engine

sources:
  - common/draw_pkg.sv
  - hdl/draw_regs.sv
  - line/line_raster.sv
  - fill/screen_fill.sv
  - hdl/draw_sequencer.sv
  - hdl/draw_engine.sv
  - target: test
    files:
      - test/draw_engine_props.sv
      - test/tb_draw_engine.sv
